// File: hw/lc3b_pkg.sv
package lc3b_pkg;

	// datapath widths
	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int NZP_W = 3;

	// LC-3b opcodes kept in this datapath
	localparam logic [3:0] OP_ADD = 4'b0001;
	localparam logic [3:0] OP_AND = 4'b0101;
	localparam logic [3:0] OP_NOT = 4'b1001;
	localparam logic [3:0] OP_LDB = 4'b0010;
	localparam logic [3:0] OP_STB = 4'b0011;
	localparam logic [3:0] OP_LDR = 4'b0110;
	localparam logic [3:0] OP_STR = 4'b0111;

	// ALU operations
	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_AND = 2'd1;
	localparam logic [1:0] ALU_NOT = 2'd2;
	localparam logic [1:0] ALU_PASS = 2'd3;

	// one instruction word, read as operate or memory format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [REG_W-1:0] dr;
			logic [REG_W-1:0] sr1;
			logic imm;
			// sr2 sits in the low three bits when imm is clear
			logic [4:0] imm5;
		} op;
		struct packed {
			logic [3:0] opcode;
			logic [REG_W-1:0] dr;
			logic [REG_W-1:0] baser;
			logic [5:0] offset6;
		} mem;
	} lc3b_instr;

endpackage

// File: hw/lc3b_regfile.sv
`timescale 1ns/100ps

module lc3b_regfile
(
	input  logic clk,
	input  logic rst,
	input  logic write,
	input  logic [lc3b_pkg::REG_W-1:0] write_dest,
	input  logic [lc3b_pkg::WORD_W-1:0] write_data,
	input  logic [lc3b_pkg::REG_W-1:0] sr1,
	input  logic [lc3b_pkg::REG_W-1:0] sr2,
	output logic [lc3b_pkg::WORD_W-1:0] sr1_data,
	output logic [lc3b_pkg::WORD_W-1:0] sr2_data
);
	import lc3b_pkg::*;

	logic [WORD_W-1:0] regs [8];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (write)
		begin
			regs[write_dest] <= write_data;
		end
	end

	// write-through covers the producer three slots ahead
	always_comb
	begin
		sr1_data = (write && write_dest == sr1) ? write_data : regs[sr1];
		sr2_data = (write && write_dest == sr2) ? write_data : regs[sr2];
	end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
(
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  lc3b_pkg::lc3b_instr instr,
	input  logic instr_valid,
	output logic [lc3b_pkg::REG_W-1:0] sr1,
	output logic [lc3b_pkg::REG_W-1:0] sr2,
	input  logic [lc3b_pkg::WORD_W-1:0] sr1_data,
	input  logic [lc3b_pkg::WORD_W-1:0] sr2_data,
	output logic id_valid,
	output logic [1:0] id_alu_op,
	output logic [lc3b_pkg::WORD_W-1:0] id_src_a,
	output logic [lc3b_pkg::WORD_W-1:0] id_src_b,
	output logic [lc3b_pkg::REG_W-1:0] id_src_a_reg,
	output logic [lc3b_pkg::REG_W-1:0] id_src_b_reg,
	output logic [lc3b_pkg::WORD_W-1:0] id_imm,
	output logic id_use_imm,
	output logic [lc3b_pkg::REG_W-1:0] id_dest,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_byte_op,
	output logic id_load_regfile,
	output logic id_load_cc
);
	import lc3b_pkg::*;

	logic known;
	logic take;
	logic [1:0] alu_op;
	logic [WORD_W-1:0] imm;
	logic [WORD_W-1:0] imm5_sext;
	logic [WORD_W-1:0] off_byte;
	logic [WORD_W-1:0] off_word;
	logic use_imm;
	logic [REG_W-1:0] dest;
	logic mem_read;
	logic mem_write;
	logic byte_op;
	logic load_regfile;
	logic load_cc;

	assign imm5_sext = {{(WORD_W-5){instr.op.imm5[4]}}, instr.op.imm5};
	assign off_byte = {{(WORD_W-6){instr.mem.offset6[5]}}, instr.mem.offset6};
	// word accesses scale the offset by two
	assign off_word = {{(WORD_W-7){instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};

	always_comb
	begin
		known = 1'b0;
		alu_op = ALU_PASS;
		imm = '0;
		use_imm = 1'b0;
		dest = instr.op.dr;
		sr1 = instr.op.sr1;
		sr2 = instr.op.imm5[REG_W-1:0];
		mem_read = 1'b0;
		mem_write = 1'b0;
		byte_op = 1'b0;
		load_regfile = 1'b0;
		load_cc = 1'b0;
		if (instr.op.opcode inside {OP_ADD, OP_AND, OP_NOT})
		begin
			known = 1'b1;
			load_regfile = 1'b1;
			load_cc = 1'b1;
			imm = imm5_sext;
			use_imm = instr.op.imm && (instr.op.opcode != OP_NOT);
			case (instr.op.opcode)
				OP_ADD: alu_op = ALU_ADD;
				OP_AND: alu_op = ALU_AND;
				default: alu_op = ALU_NOT;
			endcase
		end
		else
		begin
			// base in sr1, store source in sr2
			sr1 = instr.mem.baser;
			sr2 = instr.mem.dr;
			dest = instr.mem.dr;
			case (instr.mem.opcode)
				OP_LDR:
				begin
					known = 1'b1;
					mem_read = 1'b1;
					load_regfile = 1'b1;
					load_cc = 1'b1;
					imm = off_word;
				end
				OP_LDB:
				begin
					known = 1'b1;
					mem_read = 1'b1;
					byte_op = 1'b1;
					load_regfile = 1'b1;
					load_cc = 1'b1;
					imm = off_byte;
				end
				OP_STR:
				begin
					known = 1'b1;
					mem_write = 1'b1;
					imm = off_word;
				end
				OP_STB:
				begin
					known = 1'b1;
					mem_write = 1'b1;
					byte_op = 1'b1;
					imm = off_byte;
				end
				default:
				begin
					known = 1'b0;
				end
			endcase
		end
	end

	assign take = instr_valid && known;

	// control half of ID/EX
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			id_valid <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_load_regfile <= 1'b0;
			id_load_cc <= 1'b0;
		end
		else if (!stall)
		begin
			id_valid <= take;
			id_mem_read <= take && mem_read;
			id_mem_write <= take && mem_write;
			id_load_regfile <= take && load_regfile;
			id_load_cc <= take && load_cc;
		end
	end

	// payload half
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			id_alu_op <= alu_op;
			id_src_a <= sr1_data;
			id_src_b <= sr2_data;
			id_src_a_reg <= sr1;
			id_src_b_reg <= sr2;
			id_imm <= imm;
			id_use_imm <= use_imm;
			id_dest <= dest;
			id_byte_op <= byte_op;
		end
	end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
(
	input  logic id_valid,
	input  logic [1:0] id_alu_op,
	input  logic [lc3b_pkg::WORD_W-1:0] id_src_a,
	input  logic [lc3b_pkg::WORD_W-1:0] id_src_b,
	input  logic [lc3b_pkg::REG_W-1:0] id_src_a_reg,
	input  logic [lc3b_pkg::REG_W-1:0] id_src_b_reg,
	input  logic [lc3b_pkg::WORD_W-1:0] id_imm,
	input  logic id_use_imm,
	input  logic [lc3b_pkg::REG_W-1:0] id_dest,
	input  logic id_mem_read,
	input  logic id_mem_write,
	input  logic id_byte_op,
	input  logic id_load_regfile,
	input  logic id_load_cc,
	input  logic fwd_mem_valid,
	input  logic [lc3b_pkg::REG_W-1:0] fwd_mem_dest,
	input  logic [lc3b_pkg::WORD_W-1:0] fwd_mem_data,
	input  logic fwd_wb_valid,
	input  logic [lc3b_pkg::REG_W-1:0] fwd_wb_dest,
	input  logic [lc3b_pkg::WORD_W-1:0] fwd_wb_data,
	output logic [lc3b_pkg::WORD_W-1:0] alu_out,
	output logic [lc3b_pkg::WORD_W-1:0] addr,
	output logic [lc3b_pkg::WORD_W-1:0] store_data,
	output logic ex_valid,
	output logic [lc3b_pkg::REG_W-1:0] ex_dest,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_byte_op,
	output logic ex_load_regfile,
	output logic ex_load_cc
);
	import lc3b_pkg::*;

	logic a_mem_hit;
	logic a_wb_hit;
	logic b_mem_hit;
	logic b_wb_hit;
	logic [WORD_W-1:0] src_a;
	logic [WORD_W-1:0] src_b;
	logic [WORD_W-1:0] op_b;

	assign a_mem_hit = fwd_mem_valid && (fwd_mem_dest == id_src_a_reg);
	assign a_wb_hit = fwd_wb_valid && (fwd_wb_dest == id_src_a_reg);
	assign b_mem_hit = fwd_mem_valid && (fwd_mem_dest == id_src_b_reg);
	assign b_wb_hit = fwd_wb_valid && (fwd_wb_dest == id_src_b_reg);

	// memory stage is younger than writeback, so it is checked first
	always_comb
	begin
		if (a_mem_hit)
			src_a = fwd_mem_data;
		else if (a_wb_hit)
			src_a = fwd_wb_data;
		else
			src_a = id_src_a;

		if (b_mem_hit)
			src_b = fwd_mem_data;
		else if (b_wb_hit)
			src_b = fwd_wb_data;
		else
			src_b = id_src_b;
	end

	assign op_b = id_use_imm ? id_imm : src_b;

	always_comb
	begin
		case (id_alu_op)
			ALU_ADD: alu_out = src_a + op_b;
			ALU_AND: alu_out = src_a & op_b;
			ALU_NOT: alu_out = ~src_a;
			ALU_PASS: alu_out = op_b;
			default: alu_out = op_b;
		endcase
	end

	// base plus scaled offset
	assign addr = src_a + id_imm;
	assign store_data = src_b;

	assign ex_valid = id_valid;
	assign ex_dest = id_dest;
	assign ex_mem_read = id_mem_read;
	assign ex_mem_write = id_mem_write;
	assign ex_byte_op = id_byte_op;
	assign ex_load_regfile = id_load_regfile;
	assign ex_load_cc = id_load_cc;

endmodule

// File: hw/ex_mem_pipeline.sv
`timescale 1ns/100ps

module ex_mem_pipeline
(
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic valid_in,
	input  logic [lc3b_pkg::WORD_W-1:0] alu_out_in,
	input  logic [lc3b_pkg::WORD_W-1:0] addr_in,
	input  logic [lc3b_pkg::WORD_W-1:0] store_data_in,
	input  logic [lc3b_pkg::REG_W-1:0] dest_in,
	input  logic load_regfile_in,
	input  logic load_cc_in,
	input  logic mem_read_in,
	input  logic mem_write_in,
	input  logic byte_op_in,
	output logic valid_out,
	output logic [lc3b_pkg::WORD_W-1:0] alu_out_out,
	output logic [lc3b_pkg::WORD_W-1:0] addr_out,
	output logic [lc3b_pkg::WORD_W-1:0] store_data_out,
	output logic [lc3b_pkg::REG_W-1:0] dest_out,
	output logic load_regfile_out,
	output logic load_cc_out,
	output logic mem_read_out,
	output logic mem_write_out,
	output logic byte_op_out
);
	import lc3b_pkg::*;

	logic valid;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic [WORD_W-1:0] alu_out;
	logic [WORD_W-1:0] addr;
	logic [WORD_W-1:0] store_data;
	logic [REG_W-1:0] dest;
	logic byte_op;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid <= 1'b0;
			load_regfile <= 1'b0;
			load_cc <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end
		else if (!stall)
		begin
			valid <= valid_in;
			load_regfile <= load_regfile_in;
			load_cc <= load_cc_in;
			mem_read <= mem_read_in;
			mem_write <= mem_write_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			alu_out <= alu_out_in;
			addr <= addr_in;
			store_data <= store_data_in;
			dest <= dest_in;
			byte_op <= byte_op_in;
		end
	end

	// a bubble never reaches the memory or the register file
	always_comb
	begin
		valid_out = valid;
		load_regfile_out = valid && load_regfile;
		load_cc_out = valid && load_cc;
		mem_read_out = valid && mem_read;
		mem_write_out = valid && mem_write;
		alu_out_out = alu_out;
		addr_out = addr;
		store_data_out = store_data;
		dest_out = dest;
		byte_op_out = byte_op;
	end

	// decode never marks one instruction as both load and store
	read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read_out && mem_write_out))
		else $error("load and store strobes both high in EX/MEM");

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic valid,
	input  logic [lc3b_pkg::WORD_W-1:0] alu_out,
	input  logic [lc3b_pkg::WORD_W-1:0] addr,
	input  logic [lc3b_pkg::WORD_W-1:0] store_data,
	input  logic [lc3b_pkg::REG_W-1:0] dest,
	input  logic load_regfile,
	input  logic load_cc,
	input  logic mem_read,
	input  logic mem_write,
	input  logic byte_op,
	output logic [lc3b_pkg::WORD_W-1:0] result,
	output logic [lc3b_pkg::REG_W-1:0] mem_dest,
	output logic mem_load_regfile,
	output logic mem_load_cc
);
	import lc3b_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [WORD_W-1:0] dmem [DMEM_WORDS];
	logic [IDX_W-1:0] word_idx;
	logic [WORD_W-1:0] rd_word;
	logic [WORD_W-1:0] wr_word;
	logic [7:0] rd_byte;
	logic [WORD_W-1:0] load_data;
	logic wr_en;

	// byte address to word index, wrapping at the memory depth
	assign word_idx = addr[IDX_W:1];
	assign rd_word = dmem[word_idx];
	assign wr_en = valid && mem_write && !stall;

	// high byte at odd addresses
	always_comb
	begin
		if (!byte_op)
			wr_word = store_data;
		else if (addr[0])
			wr_word = {store_data[7:0], rd_word[7:0]};
		else
			wr_word = {rd_word[WORD_W-1:8], store_data[7:0]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (wr_en)
		begin
			dmem[word_idx] <= wr_word;
		end
	end

	assign rd_byte = addr[0] ? rd_word[WORD_W-1:8] : rd_word[7:0];
	assign load_data = byte_op ? {{(WORD_W-8){rd_byte[7]}}, rd_byte} : rd_word;

	assign result = mem_read ? load_data : alu_out;
	assign mem_dest = dest;
	assign mem_load_regfile = load_regfile;
	assign mem_load_cc = load_cc;

	// EX/MEM holds its address under stall, so the addressed word must not move
	no_write_in_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(rd_word))
		else $error("data memory changed during stall");

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage
(
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic [lc3b_pkg::WORD_W-1:0] result,
	input  logic [lc3b_pkg::REG_W-1:0] mem_dest,
	input  logic mem_load_regfile,
	input  logic mem_load_cc,
	output logic wb_valid,
	output logic [lc3b_pkg::REG_W-1:0] wb_dest,
	output logic [lc3b_pkg::WORD_W-1:0] wb_data,
	output logic [lc3b_pkg::NZP_W-1:0] nzp
);
	import lc3b_pkg::*;

	logic valid_q;
	logic cc_q;

	// MEM/WB register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
			cc_q <= 1'b0;
		end
		else if (!stall)
		begin
			valid_q <= mem_load_regfile;
			cc_q <= mem_load_cc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			wb_dest <= mem_dest;
			wb_data <= result;
		end
	end

	// one pulse per retirement, also the regfile write strobe
	assign wb_valid = valid_q && !stall;

	always_ff @(posedge clk)
	begin
		if (rst)
			nzp <= 3'b010;
		else if (wb_valid && cc_q)
			nzp <= wb_data[WORD_W-1] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;
	end

	nzp_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(nzp))
		else $error("condition codes not one-hot");

endmodule

// File: hw/lc3b_exmem_core.sv
`timescale 1ns/100ps

module lc3b_exmem_core
#(
	parameter int DMEM_WORDS = 64
)
(
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  lc3b_pkg::lc3b_instr instr,
	input  logic instr_valid,
	output logic wb_valid,
	output logic [lc3b_pkg::REG_W-1:0] wb_dest,
	output logic [lc3b_pkg::WORD_W-1:0] wb_data,
	output logic [lc3b_pkg::NZP_W-1:0] nzp
);
	import lc3b_pkg::*;

	// register file ports
	logic [REG_W-1:0] rf_sr1;
	logic [REG_W-1:0] rf_sr2;
	logic [WORD_W-1:0] rf_sr1_data;
	logic [WORD_W-1:0] rf_sr2_data;

	// ID/EX
	logic id_valid;
	logic [1:0] id_alu_op;
	logic [WORD_W-1:0] id_src_a;
	logic [WORD_W-1:0] id_src_b;
	logic [REG_W-1:0] id_src_a_reg;
	logic [REG_W-1:0] id_src_b_reg;
	logic [WORD_W-1:0] id_imm;
	logic id_use_imm;
	logic [REG_W-1:0] id_dest;
	logic id_mem_read;
	logic id_mem_write;
	logic id_byte_op;
	logic id_load_regfile;
	logic id_load_cc;

	// execute outputs
	logic [WORD_W-1:0] ex_alu_out;
	logic [WORD_W-1:0] ex_addr;
	logic [WORD_W-1:0] ex_store_data;
	logic ex_valid;
	logic [REG_W-1:0] ex_dest;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_byte_op;
	logic ex_load_regfile;
	logic ex_load_cc;

	// EX/MEM
	logic em_valid;
	logic [WORD_W-1:0] em_alu_out;
	logic [WORD_W-1:0] em_addr;
	logic [WORD_W-1:0] em_store_data;
	logic [REG_W-1:0] em_dest;
	logic em_load_regfile;
	logic em_load_cc;
	logic em_mem_read;
	logic em_mem_write;
	logic em_byte_op;

	// memory stage results, also the younger forwarding source
	logic [WORD_W-1:0] mem_result;
	logic [REG_W-1:0] mem_dest;
	logic mem_load_regfile;
	logic mem_load_cc;

	lc3b_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.write(wb_valid),
		.write_dest(wb_dest),
		.write_data(wb_data),
		.sr1(rf_sr1),
		.sr2(rf_sr2),
		.sr1_data(rf_sr1_data),
		.sr2_data(rf_sr2_data)
	);

	decode_stage u_decode (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.instr(instr),
		.instr_valid(instr_valid),
		.sr1(rf_sr1),
		.sr2(rf_sr2),
		.sr1_data(rf_sr1_data),
		.sr2_data(rf_sr2_data),
		.id_valid(id_valid),
		.id_alu_op(id_alu_op),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.id_src_a_reg(id_src_a_reg),
		.id_src_b_reg(id_src_b_reg),
		.id_imm(id_imm),
		.id_use_imm(id_use_imm),
		.id_dest(id_dest),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_byte_op(id_byte_op),
		.id_load_regfile(id_load_regfile),
		.id_load_cc(id_load_cc)
	);

	execute_stage u_execute (
		.id_valid(id_valid),
		.id_alu_op(id_alu_op),
		.id_src_a(id_src_a),
		.id_src_b(id_src_b),
		.id_src_a_reg(id_src_a_reg),
		.id_src_b_reg(id_src_b_reg),
		.id_imm(id_imm),
		.id_use_imm(id_use_imm),
		.id_dest(id_dest),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_byte_op(id_byte_op),
		.id_load_regfile(id_load_regfile),
		.id_load_cc(id_load_cc),
		.fwd_mem_valid(mem_load_regfile),
		.fwd_mem_dest(mem_dest),
		.fwd_mem_data(mem_result),
		.fwd_wb_valid(wb_valid),
		.fwd_wb_dest(wb_dest),
		.fwd_wb_data(wb_data),
		.alu_out(ex_alu_out),
		.addr(ex_addr),
		.store_data(ex_store_data),
		.ex_valid(ex_valid),
		.ex_dest(ex_dest),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_byte_op(ex_byte_op),
		.ex_load_regfile(ex_load_regfile),
		.ex_load_cc(ex_load_cc)
	);

	ex_mem_pipeline u_ex_mem (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.valid_in(ex_valid),
		.alu_out_in(ex_alu_out),
		.addr_in(ex_addr),
		.store_data_in(ex_store_data),
		.dest_in(ex_dest),
		.load_regfile_in(ex_load_regfile),
		.load_cc_in(ex_load_cc),
		.mem_read_in(ex_mem_read),
		.mem_write_in(ex_mem_write),
		.byte_op_in(ex_byte_op),
		.valid_out(em_valid),
		.alu_out_out(em_alu_out),
		.addr_out(em_addr),
		.store_data_out(em_store_data),
		.dest_out(em_dest),
		.load_regfile_out(em_load_regfile),
		.load_cc_out(em_load_cc),
		.mem_read_out(em_mem_read),
		.mem_write_out(em_mem_write),
		.byte_op_out(em_byte_op)
	);

	mem_stage #(
		.DMEM_WORDS(DMEM_WORDS)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.valid(em_valid),
		.alu_out(em_alu_out),
		.addr(em_addr),
		.store_data(em_store_data),
		.dest(em_dest),
		.load_regfile(em_load_regfile),
		.load_cc(em_load_cc),
		.mem_read(em_mem_read),
		.mem_write(em_mem_write),
		.byte_op(em_byte_op),
		.result(mem_result),
		.mem_dest(mem_dest),
		.mem_load_regfile(mem_load_regfile),
		.mem_load_cc(mem_load_cc)
	);

	writeback_stage u_writeback (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.result(mem_result),
		.mem_dest(mem_dest),
		.mem_load_regfile(mem_load_regfile),
		.mem_load_cc(mem_load_cc),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.nzp(nzp)
	);

endmodule

// File: verification/lc3b_model.sv
package lc3b_model;
	import lc3b_pkg::*;

	// architectural state as the instruction set defines it
	logic [WORD_W-1:0] reg_state [8];
	logic [WORD_W-1:0] mem_state [];
	logic [NZP_W-1:0] cc_state;

	function automatic void clear_state(input int words);
		mem_state = new[words];
		foreach (mem_state[i])
			mem_state[i] = '0;
		foreach (reg_state[i])
			reg_state[i] = '0;
		cc_state = 3'b010;
	endfunction

	function automatic logic [WORD_W-1:0] sign_extend(input logic [WORD_W-1:0] value,
		input int bits);
		logic [WORD_W-1:0] upper;
		upper = {WORD_W{1'b1}} << bits;
		if (value[bits-1])
			return value | upper;
		else
			return value & ~upper;
	endfunction

	// runs one accepted instruction, returns 1 when it writes a register
	function automatic logic execute(input lc3b_instr ins, output logic [REG_W-1:0] dest,
		output logic [WORD_W-1:0] data, output logic [NZP_W-1:0] cc_after);
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [WORD_W-1:0] base;
		logic [WORD_W-1:0] off;
		logic [WORD_W-1:0] waddr;
		logic [WORD_W-1:0] baddr;
		logic [WORD_W-1:0] src;
		int widx;
		int bidx;
		logic writes;

		// operate view
		a = reg_state[ins.op.sr1];
		if (ins.op.imm)
			b = sign_extend(ins.op.imm5, 5);
		else
			b = reg_state[ins.op.imm5[2:0]];

		// memory view
		base = reg_state[ins.mem.baser];
		src = reg_state[ins.mem.dr];
		off = sign_extend(ins.mem.offset6, 6);
		waddr = base + (off << 1);
		baddr = base + off;
		// byte address to word, wrapping over the memory depth
		widx = int'(waddr >> 1) % mem_state.size();
		bidx = int'(baddr >> 1) % mem_state.size();

		writes = 1'b1;
		dest = ins.op.dr;
		data = '0;
		case (ins.op.opcode)
			OP_ADD: data = a + b;
			OP_AND: data = a & b;
			OP_NOT: data = ~a;
			OP_LDR: data = mem_state[widx];
			OP_LDB:
			begin
				if (baddr[0])
					data = sign_extend(mem_state[bidx][WORD_W-1:8], 8);
				else
					data = sign_extend(mem_state[bidx][7:0], 8);
			end
			OP_STR:
			begin
				writes = 1'b0;
				mem_state[widx] = src;
			end
			OP_STB:
			begin
				writes = 1'b0;
				// odd address is the high byte
				if (baddr[0])
					mem_state[bidx][WORD_W-1:8] = src[7:0];
				else
					mem_state[bidx][7:0] = src[7:0];
			end
			default: writes = 1'b0;
		endcase

		if (writes)
		begin
			reg_state[dest] = data;
			if (data[WORD_W-1])
				cc_state = 3'b100;
			else if (data == '0)
				cc_state = 3'b010;
			else
				cc_state = 3'b001;
		end
		cc_after = cc_state;
		return writes;
	endfunction

endpackage

// File: verification/tb_lc3b_core.sv
`timescale 1ns/100ps

module tb_lc3b_core;
	import lc3b_pkg::*;
	import lc3b_model::*;

	localparam int DMEM_WORDS = 64;
	localparam real CLK_PERIOD = 4.0;
	localparam int N_LOADS = 16;
	localparam int N_RANDOM = 3000;
	localparam int N_TOTAL = N_LOADS + N_RANDOM;

	logic clk;
	logic rst;
	logic stall;
	lc3b_instr instr;
	logic instr_valid;
	logic wb_valid;
	logic [REG_W-1:0] wb_dest;
	logic [WORD_W-1:0] wb_data;
	logic [NZP_W-1:0] nzp;

	// expected retirements in program order
	logic [REG_W-1:0] exp_dest [$];
	logic [WORD_W-1:0] exp_data [$];
	logic [NZP_W-1:0] exp_cc [$];
	logic [NZP_W-1:0] nzp_expected = 3'b010;
	int retired = 0;

	lc3b_exmem_core #(
		.DMEM_WORDS(DMEM_WORDS)
	) u_lc3b_exmem_core (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.instr(instr),
		.instr_valid(instr_valid),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.nzp(nzp)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) clk = ~clk;
	end

	task automatic check_value(input string what, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("TEST FAIL");
			$fatal(1, "mismatch after %0d writebacks", retired);
		end
	endtask

	function automatic lc3b_instr random_instr();
		lc3b_instr word;
		logic [3:0] op;
		case ($urandom % 7)
			0: op = OP_ADD;
			1: op = OP_AND;
			2: op = OP_NOT;
			3: op = OP_LDR;
			4: op = OP_LDB;
			5: op = OP_STR;
			default: op = OP_STB;
		endcase
		word = {op, 12'($urandom)};
		// NOT carries ones in its low six bits
		if (op == OP_NOT)
		begin
			word.op.imm = 1'b1;
			word.op.imm5 = 5'h1f;
		end
		return word;
	endfunction

	function automatic lc3b_instr random_load();
		logic [3:0] op;
		op = ($urandom % 2) ? OP_LDR : OP_LDB;
		return {op, 12'($urandom)};
	endfunction

	// presents one slot and keeps it until an edge without stall takes it
	task automatic issue_slot(input logic valid, input lc3b_instr word);
		logic held;
		logic writes;
		logic [REG_W-1:0] d;
		logic [WORD_W-1:0] v;
		logic [NZP_W-1:0] c;
		instr = word;
		instr_valid = valid;
		held = 1'b1;
		while (held)
		begin
			stall = ($urandom % 100) < 15;
			held = stall;
			@(posedge clk);
			#1;
		end
		if (valid)
		begin
			writes = execute(word, d, v, c);
			if (writes)
			begin
				exp_dest.push_back(d);
				exp_data.push_back(v);
				exp_cc.push_back(c);
			end
		end
	endtask

	// outputs sampled mid-cycle
	// nzp always shows the codes of the last retired result
	always @(negedge clk)
	begin
		if (!rst)
			check_value("nzp", WORD_W'(nzp), WORD_W'(nzp_expected));
		if (!rst && wb_valid)
		begin
			if (exp_dest.size() == 0)
			begin
				$display("unexpected writeback to r%0d at %0t ns, nothing outstanding",
					wb_dest, $time);
				$display("TEST FAIL");
				$fatal(1, "extra writeback");
			end
			else
			begin
				check_value("wb_dest", WORD_W'(wb_dest), WORD_W'(exp_dest.pop_front()));
				check_value("wb_data", wb_data, exp_data.pop_front());
				nzp_expected = exp_cc.pop_front();
				retired++;
			end
		end
	end

	initial
	begin
		#(N_TOTAL * 4 * CLK_PERIOD + 200.0);
		$display("watchdog expired: the pipeline hung after %0d writebacks", retired);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial
	begin
		int drain;
		logic valid;
		lc3b_instr word;
		void'($urandom(55));
		rst = 1'b1;
		stall = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		clear_state(DMEM_WORDS);
		check_value("nzp after reset", WORD_W'(nzp), WORD_W'(3'b010));

		// loads from freshly cleared memory
		for (int i = 0; i < N_LOADS; i++)
			issue_slot(1'b1, random_load());

		// random mix, all eight registers in play for dense hazards
		for (int i = 0; i < N_RANDOM; i++)
		begin
			valid = ($urandom % 100) >= 20;
			word = random_instr();
			issue_slot(valid, word);
		end

		instr_valid = 1'b0;
		stall = 1'b0;
		drain = 0;
		while (exp_dest.size() != 0 && drain < 32)
		begin
			@(posedge clk);
			drain++;
		end
		repeat (2) @(posedge clk);

		if (exp_dest.size() != 0)
		begin
			$display("writebacks missing: %0d expected results never retired", exp_dest.size());
			$display("TEST FAIL");
			$fatal(1, "missing writebacks");
		end
		else
		begin
			$display("%0d writebacks checked", retired);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: list.f
hw/lc3b_pkg.sv
hw/lc3b_regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/ex_mem_pipeline.sv
hw/mem_stage.sv
hw/writeback_stage.sv
hw/lc3b_exmem_core.sv
verification/lc3b_model.sv
verification/tb_lc3b_core.sv

// File: Bender.yml
package:
  name: lc3b_exmem_core

sources:
  # design, in compile order
  - hw/lc3b_pkg.sv
  - hw/lc3b_regfile.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/ex_mem_pipeline.sv
  - hw/mem_stage.sv
  - hw/writeback_stage.sv
  - hw/lc3b_exmem_core.sv

  # testbench and reference model
  - target: simulation
    files:
      - verification/lc3b_model.sv
      - verification/tb_lc3b_core.sv
